//--- or1k_dbg.f
verilog/or1k_dbg_pkg.sv
verilog/or1k_dbg_burst_fsm.sv
verilog/or1k_dbg_spr_biu.sv
verilog/or1k_dbg_crc32.sv
verilog/or1k_dbg_status_reg.sv
verilog/or1k_dbg_tdo_stage.sv
verilog/or1k_dbg_top.sv
verif/or1k_dbg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the debug module testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module or1k_dbg_tb \
  -f or1k_dbg.f -o or1k_dbg_sim > build.log 2>&1 ||
{ echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/or1k_dbg_sim > sim.log 2>&1 ||
{ echo "Simulation did not run to completion, see sim.log"; exit 1; }

grep -q "^Test OK$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/or1k_dbg_stimulus.txt
// kind addr count ack_delay crc_corrupt status (bit0 stall, bit1 reset)
// kind 1 status write, 2 breakpoint, 3 write, 4 read, 5 cut read, 6 select, 0 ends
1 00000000 0 0 0 1
1 00000000 0 0 0 2
1 00000000 0 0 0 0
2 00000000 0 0 0 0
1 00000000 0 0 0 0
3 00001000 1 0 0 0
3 00001010 4 2 0 0
3 00002000 3 3 1 0
4 00001010 4 1 0 0
4 00001000 1 0 0 0
4 0000a5c0 2 3 0 0
4 fffffffe 3 0 0 0
3 fffffffe 2 1 1 0
5 00003000 4 2 0 0
6 80000000 0 0 0 0
1 00000000 0 0 0 3
6 00000000 0 1 0 0
4 00002000 3 2 0 0
0 00000000 0 0 0 0

//--- verif/or1k_dbg_tb.sv
////////////////////
// OR1K debug module testbench
// TAP shift model, SPR memory model and CRC-32 reference
////////////////////
`timescale 1ns/1ps

module or1k_dbg_tb;
  import or1k_dbg_pkg::*;

  localparam int MAX_CASES = 32;
  localparam int FIELDS    = 6;   // kind, addr, count, delay, corrupt, status
  localparam int WAIT_MAX  = 20;  // Cycles allowed for any wait loop

  logic              tck_i = 1'b0;
  logic              rst_i;
  logic              tdi_i;
  logic              capture_dr_i;
  logic              shift_dr_i;
  logic              update_dr_i;
  logic              module_select_i;
  logic [DR_W-1:0]   data_register_i;
  logic              module_tdo_o;
  logic              top_inhibit_o;
  logic [WORD_W-1:0] cpu_addr_o;
  logic [WORD_W-1:0] cpu_data_o;
  logic              cpu_stb_o;
  logic              cpu_we_o;
  logic [WORD_W-1:0] cpu_data_i = '0;
  logic              cpu_ack_i  = 1'b0;
  logic              cpu_bp_i;
  logic              cpu_stall_o;
  logic              cpu_rst_o;

  integer            seed = 32'hab3b0c1e;
  int                errors;
  logic              timed_out;          // A wait loop ran out
  int                ack_delay;          // Set per test case
  int                ack_cnt;
  logic              dr_pending;         // DR shifts at the next falling edge
  logic              exp_stall, exp_rst;
  logic [31:0]       stim [0:MAX_CASES*FIELDS-1];
  logic [WORD_W-1:0] mem [logic [WORD_W-1:0]];  // Sparse SPR space
  logic [WORD_W-1:0] wr_addr_q[$];      // Writes seen on the bus
  logic [WORD_W-1:0] wr_data_q[$];

  always #10 tck_i = ~tck_i;

  or1k_dbg_top u_dut (
    .tck_i, .rst_i, .tdi_i, .capture_dr_i, .shift_dr_i, .update_dr_i,
    .module_select_i, .data_register_i, .module_tdo_o, .top_inhibit_o,
    .cpu_addr_o, .cpu_data_o, .cpu_stb_o, .cpu_we_o, .cpu_data_i, .cpu_ack_i,
    .cpu_bp_i, .cpu_stall_o, .cpu_rst_o
  );

  ////////////////////
  // Reference models
  function automatic logic [WORD_W-1:0] fill_word(input logic [WORD_W-1:0] a);
    fill_word = (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};  // Untouched SPR contents
  endfunction

  function automatic logic [WORD_W-1:0] mem_read(input logic [WORD_W-1:0] a);
    if (mem.exists(a)) mem_read = mem[a];
    else mem_read = fill_word(a);
  endfunction

  // One bit of reflected CRC-32 without final inversion
  function automatic logic [WORD_W-1:0] crc_next(input logic [WORD_W-1:0] crc, input logic b);
    logic fb;
    fb = crc[0] ^ b;
    crc_next = {1'b0, crc[WORD_W-1:1]};
    if (fb) crc_next = crc_next ^ CRC_POLY;
  endfunction

  // SPR slave acks after ack_delay cycles of strobe
  always @(negedge tck_i) begin
    if (cpu_ack_i || !cpu_stb_o) begin
      cpu_ack_i = 1'b0;
      ack_cnt   = 0;
    end else if (ack_cnt >= ack_delay) begin
      cpu_ack_i = 1'b1;
      if (cpu_we_o) begin
        mem[cpu_addr_o] = cpu_data_o;
        wr_addr_q.push_back(cpu_addr_o);
        wr_data_q.push_back(cpu_data_o);
      end else begin
        cpu_data_i = mem_read(cpu_addr_o);
      end
    end else begin
      ack_cnt++;
    end
  end

  ////////////////////
  // Reporting
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("FAILED %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout: %s", what);
  endtask

  ////////////////////
  // TAP model
  task automatic next_cycle;
    @(negedge tck_i);
    if (dr_pending) data_register_i = {tdi_i, data_register_i[DR_W-1:1]};
    dr_pending   = 1'b0;
    capture_dr_i = 1'b0;
    shift_dr_i   = 1'b0;
    update_dr_i  = 1'b0;
  endtask

  task automatic shift_bit(input logic b, output logic tdo);
    next_cycle();
    shift_dr_i = 1'b1;
    tdi_i      = b;
    dr_pending = 1'b1;
    #1 tdo = module_tdo_o;  // TDO settled before the rising edge
  endtask

  task automatic do_capture;
    next_cycle();
    capture_dr_i    = 1'b1;
    data_register_i = '0;  // Captured value is all zero
  endtask

  task automatic do_update(input logic [DR_W-1:0] value);
    next_cycle();
    data_register_i = value;
    update_dr_i     = 1'b1;
  endtask

  task automatic end_burst;
    next_cycle();
    update_dr_i = 1'b1;  // DR left as shifted
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic [31:0] addr,
                          input logic [15:0] cnt);
    do_update({1'b0, op, addr, cnt});
  endtask

  task automatic wait_bus_idle;
    int n;
    n = 0;
    while ((cpu_stb_o || cpu_ack_i) && n < WAIT_MAX) begin
      next_cycle();
      n++;
    end
    if (cpu_stb_o || cpu_ack_i) report_timeout("SPR bus access never completed");
  endtask

  ////////////////////
  // Status register
  task automatic check_status;
    logic s, r;
    do_capture();
    shift_bit(1'b0, s);  // Stall first
    shift_bit(1'b0, r);
    if (s !== exp_stall) report_mismatch("module_tdo_o (stall)", s, exp_stall);
    if (r !== exp_rst) report_mismatch("module_tdo_o (reset)", r, exp_rst);
    if (cpu_stall_o !== exp_stall) report_mismatch("cpu_stall_o", cpu_stall_o, exp_stall);
    if (cpu_rst_o !== exp_rst) report_mismatch("cpu_rst_o", cpu_rst_o, exp_rst);
  endtask

  task automatic status_write(input logic stall, input logic rst);
    do_update({1'b0, CMD_IREG_WR, 1'b0, rst, stall, 45'b0});
    exp_stall = stall;
    exp_rst   = rst;
    next_cycle();
    check_status();
  endtask

  task automatic breakpoint_pulse;
    next_cycle();
    cpu_bp_i = 1'b1;
    next_cycle();
    cpu_bp_i  = 1'b0;
    exp_stall = 1'b1;
    if (cpu_stall_o !== 1'b1) report_mismatch("cpu_stall_o", cpu_stall_o, 1'b1);
    check_status();
  endtask

  ////////////////////
  // Bursts
  task automatic write_burst(input logic [31:0] addr, input int n, input logic corrupt);
    logic [WORD_W-1:0] words[$];
    logic [WORD_W-1:0] w, crc;
    logic              o;
    words.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    send_cmd(CMD_BWRITE32, addr, 16'(n));
    do_capture();
    shift_bit(1'b1, o);  // Start bit
    crc = CRC_INIT;
    for (int i = 0; i < n; i++) begin
      w = $random(seed);
      words.push_back(w);
      for (int b = 0; b < WORD_W; b++) begin
        shift_bit(w[b], o);
        crc = crc_next(crc, w[b]);
      end
    end
    if (corrupt) crc[5] = ~crc[5];
    for (int b = 0; b < WORD_W; b++) shift_bit(crc[b], o);
    shift_bit(1'b0, o);  // Match bit cycle
    if (o !== !corrupt) report_mismatch("module_tdo_o (match)", o, !corrupt);
    end_burst();
    wait_bus_idle();
    if (wr_addr_q.size() != n) report_mismatch("write count", wr_addr_q.size(), n);
    for (int i = 0; i < n && i < wr_addr_q.size(); i++) begin
      if (wr_addr_q[i] !== addr + i) report_mismatch("cpu_addr_o", wr_addr_q[i], addr + i);
      if (wr_data_q[i] !== words[i]) report_mismatch("cpu_data_o", wr_data_q[i], words[i]);
    end
  endtask

  // Command, capture and ready poll shared by read bursts
  task automatic start_read(input logic [31:0] addr, input int n);
    logic o;
    int   tries;
    send_cmd(CMD_BREAD32, addr, 16'(n));
    next_cycle();  // First strobe goes out here
    do_capture();
    o     = 1'b0;
    tries = 0;
    while (!o && tries < WAIT_MAX) begin
      shift_bit(1'b0, o);
      tries++;
    end
    if (!o) report_timeout("bus ready bit never read 1");
  endtask

  task automatic read_burst(input logic [31:0] addr, input int n);
    logic [WORD_W-1:0] got, exp, crc, crc_got;
    logic              o, inhibit_ok;
    start_read(addr, n);
    if (timed_out) return;
    crc        = CRC_INIT;
    inhibit_ok = 1'b1;
    for (int i = 0; i < n; i++) begin
      exp = mem_read(addr + i);
      for (int b = 0; b < WORD_W; b++) begin
        shift_bit(1'b0, o);
        got[b] = o;
        crc    = crc_next(crc, exp[b]);
        if (top_inhibit_o !== 1'b1) inhibit_ok = 1'b0;
      end
      if (got !== exp) report_mismatch("module_tdo_o (read word)", got, exp);
    end
    for (int b = 0; b < WORD_W; b++) begin
      shift_bit(1'b0, o);
      crc_got[b] = o;
    end
    if (crc_got !== crc) report_mismatch("module_tdo_o (read CRC)", crc_got, crc);
    if (!inhibit_ok) report_mismatch("top_inhibit_o", 1'b0, 1'b1);
    end_burst();
    wait_bus_idle();
  endtask

  // Update in the middle of the second word
  task automatic cut_read(input logic [31:0] addr, input int n);
    logic o;
    start_read(addr, n);
    if (timed_out) return;
    for (int b = 0; b < 40; b++) shift_bit(1'b0, o);
    end_burst();
    next_cycle();
    if (top_inhibit_o !== 1'b0) report_mismatch("top_inhibit_o", top_inhibit_o, 1'b0);
    wait_bus_idle();
    check_status();
  endtask

  task automatic run_case(input int idx);
    logic [31:0] kind, addr, cnt, stat, corrupt;
    kind      = stim[idx*FIELDS];
    addr      = stim[idx*FIELDS+1];
    cnt       = stim[idx*FIELDS+2];
    ack_delay = int'(stim[idx*FIELDS+3]);
    corrupt   = stim[idx*FIELDS+4];
    stat      = stim[idx*FIELDS+5];
    case (kind)
      1: status_write(stat[0], stat[1]);
      2: breakpoint_pulse();
      3: write_burst(addr, int'(cnt), corrupt[0]);
      4: read_burst(addr, int'(cnt));
      5: cut_read(addr, int'(cnt));
      6: begin
        send_cmd(CMD_IREG_SEL, addr, 16'h0);  // Selects the only register
        next_cycle();
        check_status();
      end
      default: begin
        errors++;
        $display("Unknown test case kind %0d in line %0d", kind, idx);
      end
    endcase
    repeat (2) next_cycle();
  endtask

  ////////////////////
  // Main sequence
  initial begin
    int ci;
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;
    data_register_i = '0;
    cpu_bp_i        = 1'b0;
    dr_pending      = 1'b0;
    ack_delay       = 0;
    ack_cnt         = 0;
    errors          = 0;
    timed_out       = 1'b0;
    exp_stall       = 1'b0;
    exp_rst         = 1'b0;
    for (int i = 0; i < MAX_CASES*FIELDS; i++) stim[i] = '0;
    $readmemh("verif/or1k_dbg_stimulus.txt", stim);

    repeat (16) @(negedge tck_i);
    rst_i = 1'b0;
    next_cycle();
    if (module_tdo_o !== 1'b0) report_mismatch("module_tdo_o", module_tdo_o, 1'b0);
    if (top_inhibit_o !== 1'b0) report_mismatch("top_inhibit_o", top_inhibit_o, 1'b0);
    if (cpu_stb_o !== 1'b0) report_mismatch("cpu_stb_o", cpu_stb_o, 1'b0);
    if (cpu_we_o !== 1'b0) report_mismatch("cpu_we_o", cpu_we_o, 1'b0);
    if (cpu_stall_o !== 1'b0) report_mismatch("cpu_stall_o", cpu_stall_o, 1'b0);
    if (cpu_rst_o !== 1'b0) report_mismatch("cpu_rst_o", cpu_rst_o, 1'b0);

    ci = 0;
    while (ci < MAX_CASES && stim[ci*FIELDS] != 0 && !timed_out) begin
      run_case(ci);
      ci++;
    end
    if (ci == 0) begin
      errors++;
      $display("No test cases were read from the stimulus file");
    end

    $display("Cases run: %0d, errors: %0d", ci, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/or1k_dbg_burst_fsm.sv
////////////////////
// Command decode and burst control FSM
// Address, word, bit and opcode registers
////////////////////
`timescale 1ns/1ps

module or1k_dbg_burst_fsm (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  logic                              capture_dr_i,
  input  logic                              shift_dr_i,
  input  logic                              update_dr_i,
  input  logic                              module_select_i,
  input  logic [or1k_dbg_pkg::DR_W-1:0]     data_register_i,
  input  logic                              biu_ready_i,
  output logic                              biu_strobe_o,    // Start one SPR access
  output logic [or1k_dbg_pkg::WORD_W-1:0]   biu_addr_o,
  output logic                              biu_rd_o,
  output logic                              crc_clr_o,
  output logic                              crc_en_o,
  output logic                              crc_rd_sel_o,    // 1 = TDO data, 0 = tdi
  output logic                              crc_shift_o,
  output logic                              out_ld_o,        // Load bus read data
  output logic                              out_ld_status_o, // Load status register
  output logic                              out_shift_o,
  output or1k_dbg_pkg::tdo_sel_t            tdo_sel_o,
  output logic                              status_we_o,
  output logic                              top_inhibit_o
);
  import or1k_dbg_pkg::*;

  burst_state_t      state_q, state_d;
  logic [WORD_W-1:0] addr_q;      // Next SPR address
  logic [CNT_W-1:0]  word_cnt_q;  // Words left in burst
  logic [5:0]        bit_cnt_q;   // Bits of the current word or CRC
  logic [OP_W-1:0]   op_q;        // Latched burst opcode

  logic [OP_W-1:0]   op_in;
  logic              cmd_update;  // Update of a command for this module
  logic              burst_cmd;
  logic              word_zero, more_words, bit_max, bit_32;
  logic              load_cmd, word_dec, bit_clr, bit_inc;
  logic              rd_next;     // Load next read word and prefetch

  ////////////////////
  // Decode
  assign op_in      = data_register_i[OP_HI:OP_LO];
  assign cmd_update = module_select_i & update_dr_i & ~data_register_i[CMD_BIT];
  assign burst_cmd  = (op_in == CMD_BWRITE32) || (op_in == CMD_BREAD32);
  assign word_zero  = (word_cnt_q == '0);
  assign more_words = (word_cnt_q > CNT_W'(1));  // Another word after this one
  assign bit_max    = (bit_cnt_q == 6'(WORD_W - 1));
  assign bit_32     = (bit_cnt_q == 6'(WORD_W));

  assign biu_addr_o = addr_q;
  assign biu_rd_o   = op_q[OP_RD_BIT];

  ////////////////////
  // Counters and state
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      addr_q     <= '0;
      word_cnt_q <= '0;
      bit_cnt_q  <= '0;
      op_q       <= '0;
    end else begin
      state_q <= state_d;
      if (load_cmd) begin
        addr_q     <= data_register_i[ADDR_HI:ADDR_LO];
        word_cnt_q <= data_register_i[CNT_HI:CNT_LO];
        op_q       <= op_in;
      end else begin
        if (biu_strobe_o) addr_q <= addr_q + 1'b1;  // Post-increment per access
        if (word_dec) word_cnt_q <= word_cnt_q - 1'b1;
      end
      if (bit_clr) begin
        bit_cnt_q <= '0;
      end else if (bit_inc) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Next state and controls
  always_comb begin
    state_d         = state_q;
    load_cmd        = 1'b0;
    word_dec        = 1'b0;
    bit_clr         = 1'b0;
    bit_inc         = 1'b0;
    rd_next         = 1'b0;
    biu_strobe_o    = 1'b0;
    crc_clr_o       = 1'b0;
    crc_en_o        = 1'b0;
    crc_rd_sel_o    = 1'b0;
    crc_shift_o     = 1'b0;
    out_ld_o        = 1'b0;
    out_ld_status_o = 1'b0;
    out_shift_o     = 1'b0;
    tdo_sel_o       = TDO_DATA;
    status_we_o     = 1'b0;
    top_inhibit_o   = 1'b0;

    case (state_q)
      IDLE: begin
        out_ld_status_o = module_select_i & capture_dr_i;  // Status readback
        out_shift_o     = module_select_i & shift_dr_i;
        if (cmd_update) begin
          // Only one internal register, so a select command is a no-op
          status_we_o = (op_in == CMD_IREG_WR) &&
                        (data_register_i[REGSEL_BIT] == INTREG_STATUS);
          if (burst_cmd) begin
            load_cmd  = 1'b1;
            bit_clr   = 1'b1;
            crc_clr_o = 1'b1;
            state_d   = op_in[OP_RD_BIT] ? RBEGIN : WREADY;
          end
        end
      end
      RBEGIN: begin
        if (word_zero) begin
          state_d = IDLE;  // Empty burst
        end else begin
          biu_strobe_o = 1'b1;  // Fetch first word early
          state_d      = RREADY;
        end
      end
      RREADY: begin
        if (update_dr_i) state_d = IDLE;
        else if (module_select_i && capture_dr_i) state_d = RSTATUS;
      end
      RSTATUS: begin
        tdo_sel_o     = TDO_READY;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (biu_ready_i && shift_dr_i) begin
          rd_next = 1'b1;
          state_d = RBURST;
        end
      end
      RBURST: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (shift_dr_i) begin
          out_shift_o  = 1'b1;
          bit_inc      = 1'b1;
          crc_en_o     = 1'b1;
          crc_rd_sel_o = 1'b1;
          if (bit_max) begin
            if (word_zero) state_d = RCRC;
            else rd_next = 1'b1;
          end
        end
      end
      RCRC: begin
        tdo_sel_o     = TDO_CRC;
        top_inhibit_o = 1'b1;
        crc_shift_o   = shift_dr_i;
        if (update_dr_i) state_d = IDLE;  // Holds here until the host ends
      end
      WREADY: begin
        if (update_dr_i || word_zero) state_d = IDLE;
        else if (module_select_i && capture_dr_i) state_d = WWAIT;
      end
      WWAIT: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (module_select_i && shift_dr_i && data_register_i[CMD_BIT]) begin
          // Start bit seen, tdi already carries data bit 0
          bit_inc  = 1'b1;
          word_dec = 1'b1;
          crc_en_o = 1'b1;
          state_d  = WBURST;
        end
      end
      WBURST: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (shift_dr_i) begin
          bit_inc  = 1'b1;
          crc_en_o = 1'b1;
          if (bit_max) begin  // Last bit on tdi, word complete
            bit_clr      = 1'b1;
            biu_strobe_o = 1'b1;
            word_dec     = 1'b1;
            if (word_zero) state_d = WCRC;
          end
        end
      end
      WCRC: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (bit_32) begin
          tdo_sel_o = TDO_MATCH;  // Host samples match on this shift
          state_d   = WMATCH;
        end else if (shift_dr_i) begin
          bit_inc = 1'b1;
        end
      end
      WMATCH: begin
        tdo_sel_o     = TDO_MATCH;
        top_inhibit_o = 1'b1;
        if (update_dr_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase

    // Read word boundary
    if (rd_next) begin
      out_ld_o     = 1'b1;
      bit_clr      = 1'b1;
      word_dec     = 1'b1;
      biu_strobe_o = more_words;
    end
  end

endmodule

//--- verilog/or1k_dbg_crc32.sv
////////////////////
// Serial reflected CRC-32
// Doubles as its own output shift register
////////////////////
`timescale 1ns/1ps

module or1k_dbg_crc32 (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  logic                              tdi_i,     // Write data bit
  input  logic                              rd_bit_i,  // Read data bit on TDO
  input  logic                              rd_sel_i,
  input  logic                              clr_i,
  input  logic                              en_i,      // Add one bit
  input  logic                              shift_i,   // Shift CRC out
  output logic [or1k_dbg_pkg::WORD_W-1:0]   crc_o,
  output logic                              serial_o
);
  import or1k_dbg_pkg::*;

  logic [WORD_W-1:0] crc_q;
  logic              in_bit;
  logic              fb;  // Feedback bit

  assign in_bit = rd_sel_i ? rd_bit_i : tdi_i;
  assign fb     = crc_q[0] ^ in_bit;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= CRC_INIT;
    end else if (clr_i) begin
      crc_q <= CRC_INIT;
    end else if (en_i) begin
      crc_q <= {1'b0, crc_q[WORD_W-1:1]} ^ (fb ? CRC_POLY : '0);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[WORD_W-1:1]};  // LSB first onto TDO
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

//--- verilog/or1k_dbg_pkg.sv
////////////////////
// OR1K debug module shared definitions
// Command format, opcodes, CRC constants and FSM encodings
////////////////////
package or1k_dbg_pkg;

  ////////////////////
  // Widths
  localparam int DR_W   = 53;  // TAP data register
  localparam int WORD_W = 32;  // SPR bus word
  localparam int CNT_W  = 16;  // Burst word count
  localparam int OP_W   = 4;   // Module opcode

  ////////////////////
  // Command field positions
  localparam int CMD_BIT = 52;  // 0 selects this module
  localparam int OP_HI   = 51;
  localparam int OP_LO   = 48;
  localparam int ADDR_HI = 47;
  localparam int ADDR_LO = 16;
  localparam int CNT_HI  = 15;
  localparam int CNT_LO  = 0;
  localparam int STAT_HI = 46;  // Reset bit of a status write
  localparam int STAT_LO = 45;  // Stall bit of a status write

  // Opcodes
  localparam logic [OP_W-1:0] CMD_BWRITE32 = 4'd3;
  localparam logic [OP_W-1:0] CMD_BREAD32  = 4'd7;
  localparam logic [OP_W-1:0] CMD_IREG_WR  = 4'd9;
  localparam logic [OP_W-1:0] CMD_IREG_SEL = 4'd13;
  localparam int              OP_RD_BIT    = 2;  // Set for reads

  // Internal register select
  localparam int   REGSEL_BIT    = 47;
  localparam logic INTREG_STATUS = 1'b0;

  ////////////////////
  // CRC-32, reflected
  localparam logic [WORD_W-1:0] CRC_POLY = 32'hedb8_8320;
  localparam logic [WORD_W-1:0] CRC_INIT = 32'hffff_ffff;

  // TDO source select
  typedef enum logic [1:0] {
    TDO_READY,  // Bus ready flag
    TDO_DATA,   // Output shift register LSB
    TDO_MATCH,  // Write CRC match
    TDO_CRC     // Serial CRC
  } tdo_sel_t;

  // Burst FSM states
  typedef enum logic [3:0] {
    IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
    WREADY, WWAIT, WBURST, WCRC, WMATCH
  } burst_state_t;

endpackage

//--- verilog/or1k_dbg_spr_biu.sv
////////////////////
// SPR bus unit
// One strobe/acknowledge access per request
////////////////////
`timescale 1ns/1ps

module or1k_dbg_spr_biu (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  logic                              strobe_i,   // Latch and start access
  input  logic [or1k_dbg_pkg::WORD_W-1:0]   addr_i,
  input  logic                              rd_i,
  input  logic [or1k_dbg_pkg::DR_W-1:0]     data_register_i,
  input  logic                              tdi_i,
  input  logic [or1k_dbg_pkg::WORD_W-1:0]   cpu_data_i,
  input  logic                              cpu_ack_i,
  output logic [or1k_dbg_pkg::WORD_W-1:0]   rd_data_o,
  output logic                              ready_o,
  output logic [or1k_dbg_pkg::WORD_W-1:0]   cpu_addr_o,
  output logic [or1k_dbg_pkg::WORD_W-1:0]   cpu_data_o,
  output logic                              cpu_stb_o,
  output logic                              cpu_we_o
);
  import or1k_dbg_pkg::*;

  logic [WORD_W-1:0] wr_word;   // Word just shifted in
  logic [WORD_W-1:0] addr_q;
  logic [WORD_W-1:0] wdata_q;
  logic [WORD_W-1:0] rdata_q;
  logic              stb_q;
  logic              we_q;
  logic              ready_q;

  // Bit 31 is still on tdi, bits 30..0 sit at the top of the DR
  assign wr_word = {tdi_i, data_register_i[CMD_BIT:CMD_BIT-(WORD_W-2)]};

  // Transaction payload
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      addr_q  <= addr_i;
      wdata_q <= wr_word;
    end
    if (stb_q && cpu_ack_i && !we_q) begin
      rdata_q <= cpu_data_i;  // Capture in the ack cycle
    end
  end

  ////////////////////
  // Handshake
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q   <= 1'b0;
      we_q    <= 1'b0;
      ready_q <= 1'b1;
    end else if (strobe_i) begin
      stb_q   <= 1'b1;
      we_q    <= ~rd_i;
      ready_q <= 1'b0;  // Busy until acknowledged
    end else if (stb_q && cpu_ack_i) begin
      stb_q   <= 1'b0;
      ready_q <= 1'b1;
    end
  end

  assign cpu_addr_o = addr_q;
  assign cpu_data_o = wdata_q;
  assign cpu_stb_o  = stb_q;
  assign cpu_we_o   = we_q;
  assign rd_data_o  = rdata_q;
  assign ready_o    = ready_q;

endmodule

//--- verilog/or1k_dbg_status_reg.sv
////////////////////
// CPU stall and reset control register
// Host writable, breakpoint sets stall
////////////////////
`timescale 1ns/1ps

module or1k_dbg_status_reg (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  logic                              we_i,
  input  logic [or1k_dbg_pkg::DR_W-1:0]     data_register_i,
  input  logic                              cpu_bp_i,
  output logic [1:0]                        status_o,   // {reset, stall}
  output logic                              cpu_stall_o,
  output logic                              cpu_rst_o
);
  import or1k_dbg_pkg::*;

  logic stall_q;
  logic cpu_rst_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_q   <= 1'b0;
      cpu_rst_q <= 1'b0;
    end else begin
      if (we_i) begin
        cpu_rst_q <= data_register_i[STAT_HI];
      end
      // Breakpoint wins over a host clear
      if (cpu_bp_i) begin
        stall_q <= 1'b1;
      end else if (we_i) begin
        stall_q <= data_register_i[STAT_LO];
      end
    end
  end

  assign status_o    = {cpu_rst_q, stall_q};
  assign cpu_stall_o = stall_q;
  assign cpu_rst_o   = cpu_rst_q;

endmodule

//--- verilog/or1k_dbg_tdo_stage.sv
////////////////////
// Output shift register, CRC match and TDO mux
////////////////////
`timescale 1ns/1ps

module or1k_dbg_tdo_stage (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  logic                              ld_i,         // Load bus read data
  input  logic                              ld_status_i,  // Load status bits
  input  logic                              shift_i,
  input  logic [or1k_dbg_pkg::WORD_W-1:0]   rd_data_i,
  input  logic [1:0]                        status_i,
  input  logic                              biu_ready_i,
  input  logic [or1k_dbg_pkg::WORD_W-1:0]   crc_i,
  input  logic                              crc_serial_i,
  input  logic [or1k_dbg_pkg::DR_W-1:0]     data_register_i,
  input  or1k_dbg_pkg::tdo_sel_t            tdo_sel_i,
  output logic                              module_tdo_o,
  output logic                              rd_bit_o      // Bit on TDO, for read CRC
);
  import or1k_dbg_pkg::*;

  logic [WORD_W-1:0] out_q;
  logic              crc_match;

  ////////////////////
  // Output register
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;  // Keeps TDO low out of reset
    end else if (ld_status_i) begin
      out_q <= {{(WORD_W-2){1'b0}}, status_i};  // Stall lands in bit 0
    end else if (ld_i) begin
      out_q <= rd_data_i;
    end else if (shift_i) begin
      out_q <= {1'b0, out_q[WORD_W-1:1]};
    end
  end

  assign rd_bit_o = out_q[0];

  // Host CRC fills the top 32 DR bits after 32 shifts
  assign crc_match = (data_register_i[CMD_BIT:CMD_BIT-(WORD_W-1)] == crc_i);

  always_comb begin
    case (tdo_sel_i)
      TDO_READY: module_tdo_o = biu_ready_i;
      TDO_DATA:  module_tdo_o = out_q[0];
      TDO_MATCH: module_tdo_o = crc_match;
      default:   module_tdo_o = crc_serial_i;
    endcase
  end

endmodule

//--- verilog/or1k_dbg_top.sv
////////////////////
// OR1K CPU debug module top level
// Burst FSM, SPR bus unit, CRC, status register and TDO stage
////////////////////
`timescale 1ns/1ps

module or1k_dbg_top (
  input  logic                              tck_i,
  input  logic                              rst_i,
  // TAP side
  input  logic                              tdi_i,
  input  logic                              capture_dr_i,
  input  logic                              shift_dr_i,
  input  logic                              update_dr_i,
  input  logic                              module_select_i,
  input  logic [or1k_dbg_pkg::DR_W-1:0]     data_register_i,
  output logic                              module_tdo_o,
  output logic                              top_inhibit_o,
  // SPR bus
  output logic [or1k_dbg_pkg::WORD_W-1:0]   cpu_addr_o,
  output logic [or1k_dbg_pkg::WORD_W-1:0]   cpu_data_o,
  output logic                              cpu_stb_o,
  output logic                              cpu_we_o,
  input  logic [or1k_dbg_pkg::WORD_W-1:0]   cpu_data_i,
  input  logic                              cpu_ack_i,
  // CPU control
  input  logic                              cpu_bp_i,
  output logic                              cpu_stall_o,
  output logic                              cpu_rst_o
);
  import or1k_dbg_pkg::*;

  // Bus unit hookup
  logic              biu_strobe;
  logic [WORD_W-1:0] biu_addr;
  logic              biu_rd;
  logic [WORD_W-1:0] biu_rd_data;
  logic              biu_ready;
  // CRC hookup
  logic              crc_clr, crc_en, crc_rd_sel, crc_shift;
  logic [WORD_W-1:0] crc_val;
  logic              crc_serial;
  // Output register, status and TDO select
  logic              out_ld, out_ld_status, out_shift;
  logic              rd_bit;      // Read data bit now on TDO
  logic              status_we;
  logic [1:0]        status;      // {reset, stall}
  tdo_sel_t          tdo_sel;

  or1k_dbg_burst_fsm u_fsm (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .data_register_i, .biu_ready_i(biu_ready),
    .biu_strobe_o(biu_strobe), .biu_addr_o(biu_addr), .biu_rd_o(biu_rd),
    .crc_clr_o(crc_clr), .crc_en_o(crc_en), .crc_rd_sel_o(crc_rd_sel),
    .crc_shift_o(crc_shift),
    .out_ld_o(out_ld), .out_ld_status_o(out_ld_status), .out_shift_o(out_shift),
    .tdo_sel_o(tdo_sel), .status_we_o(status_we), .top_inhibit_o
  );

  or1k_dbg_spr_biu u_biu (
    .tck_i, .rst_i, .strobe_i(biu_strobe), .addr_i(biu_addr), .rd_i(biu_rd),
    .data_register_i, .tdi_i, .cpu_data_i, .cpu_ack_i,
    .rd_data_o(biu_rd_data), .ready_o(biu_ready),
    .cpu_addr_o, .cpu_data_o, .cpu_stb_o, .cpu_we_o
  );

  or1k_dbg_crc32 u_crc (
    .tck_i, .rst_i, .tdi_i, .rd_bit_i(rd_bit), .rd_sel_i(crc_rd_sel),
    .clr_i(crc_clr), .en_i(crc_en), .shift_i(crc_shift),
    .crc_o(crc_val), .serial_o(crc_serial)
  );

  or1k_dbg_status_reg u_status (
    .tck_i, .rst_i, .we_i(status_we), .data_register_i, .cpu_bp_i,
    .status_o(status), .cpu_stall_o, .cpu_rst_o
  );

  or1k_dbg_tdo_stage u_tdo (
    .tck_i, .rst_i, .ld_i(out_ld), .ld_status_i(out_ld_status), .shift_i(out_shift),
    .rd_data_i(biu_rd_data), .status_i(status), .biu_ready_i(biu_ready),
    .crc_i(crc_val), .crc_serial_i(crc_serial), .data_register_i,
    .tdo_sel_i(tdo_sel), .module_tdo_o, .rd_bit_o(rd_bit)
  );

endmodule
